// File: Bender.yml
package:
  name: riscv_core

sources:
  - riscv_pkg.sv
  - alu.sv
  - reg_file.sv
  - imm_extend.sv
  - main_decoder.sv
  - alu_decoder.sv
  - datapath.sv
  - riscv_core.sv
  - target: simulation
    files:
      - tb_clock.sv
      - riscv_core_asserts.sv
      - tb_riscv_core.sv

// File: alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [riscv_pkg::xlen-1:0] a,
    input  logic [riscv_pkg::xlen-1:0] b,
    input  riscv_pkg::alu_ctrl_t       alu_ctrl,
    output logic [riscv_pkg::xlen-1:0] result,
    output logic                       zero
);
    import riscv_pkg::*;

    logic lt_signed;

    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (alu_ctrl)
            alu_add:   result = a + b;
            alu_sub:   result = a - b;
            alu_and:   result = a & b;
            alu_or:    result = a | b;
            alu_slt:   result = {{(xlen-1){1'b0}}, lt_signed};
            alu_passb: result = b;            // lui goes straight through
            default:   result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: alu_decoder.sv
`timescale 1ns/1ns

module alu_decoder (
    input  riscv_pkg::alu_op_t   alu_op,
    input  logic [2:0]           funct3,
    input  logic                 funct7_b5,
    input  logic                 op_b5,
    output riscv_pkg::alu_ctrl_t alu_ctrl
);
    import riscv_pkg::*;

    always_comb begin
        case (alu_op)
            alu_op_add:   alu_ctrl = alu_add;
            alu_op_sub:   alu_ctrl = alu_sub;
            alu_op_passb: alu_ctrl = alu_passb;
            default: begin
                case (funct3)
                    3'b000: begin
                        // only r-type can subtract, addi stays add
                        if (op_b5 && funct7_b5) begin
                            alu_ctrl = alu_sub;
                        end else begin
                            alu_ctrl = alu_add;
                        end
                    end
                    3'b010:  alu_ctrl = alu_slt;
                    3'b110:  alu_ctrl = alu_or;
                    3'b111:  alu_ctrl = alu_and;
                    default: alu_ctrl = alu_add;  // unsupported funct3
                endcase
            end
        endcase
    end

endmodule

// File: datapath.sv
`timescale 1ns/1ns

module datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    input  riscv_pkg::ctrl_t           ctrl,
    input  logic                       pc_src,
    input  riscv_pkg::alu_ctrl_t       alu_ctrl,
    input  riscv_pkg::instr_t          instr,
    input  logic [riscv_pkg::xlen-1:0] read_data,
    output logic [riscv_pkg::xlen-1:0] pc,
    output logic [riscv_pkg::xlen-1:0] data_addr,
    output logic [riscv_pkg::xlen-1:0] write_data,
    output logic                       zero,
    output logic                       mem_write
);
    import riscv_pkg::*;

    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] result;

    assign pc_plus4  = pc + xlen'(4);
    assign pc_target = pc + imm_ext;       // beq and jal share one adder
    assign pc_next   = pc_src ? pc_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // register writes are held off during reset inside reg_file
    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (ctrl.reg_write),
        .ra1   (instr.r_fmt.rs1),
        .ra2   (instr.r_fmt.rs2),
        .wa    (instr.r_fmt.rd),
        .wd    (result),
        .rd1   (src_a),
        .rd2   (rs2_data)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm_ext (imm_ext)
    );

    assign src_b = ctrl.alu_src ? imm_ext : rs2_data;

    alu u_alu (
        .a        (src_a),
        .b        (src_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .zero     (zero)
    );

    always_comb begin
        case (ctrl.result_src)
            res_mem: result = read_data;
            res_pc4: result = pc_plus4;    // jal link
            default: result = alu_result;
        endcase
    end

    assign data_addr  = alu_result;
    assign write_data = rs2_data;
    assign mem_write  = ctrl.mem_write & rst_n;  // no stores while in reset

endmodule

// File: imm_extend.sv
`timescale 1ns/1ns

module imm_extend (
    input  riscv_pkg::instr_t          instr,
    input  riscv_pkg::imm_src_t        imm_src,
    output logic [riscv_pkg::xlen-1:0] imm_ext
);
    import riscv_pkg::*;

    always_comb begin
        case (imm_src)
            imm_i: imm_ext = {{(xlen-12){instr.i_fmt.imm11_0[11]}}, instr.i_fmt.imm11_0};
            imm_s: imm_ext = {{(xlen-12){instr.s_fmt.imm11_5[6]}},
                              instr.s_fmt.imm11_5, instr.s_fmt.imm4_0};
            imm_b: imm_ext = {{(xlen-12){instr.b_fmt.imm12}},
                              instr.b_fmt.imm11,
                              instr.b_fmt.imm10_5,
                              instr.b_fmt.imm4_1,
                              1'b0};             // halfword aligned offset
            imm_j: imm_ext = {{(xlen-20){instr.j_fmt.imm20}},
                              instr.j_fmt.imm19_12,
                              instr.j_fmt.imm11,
                              instr.j_fmt.imm10_1,
                              1'b0};
            imm_u: imm_ext = {instr.u_fmt.imm31_12, 12'b0};  // upper 20 bits
            default: imm_ext = '0;
        endcase
    end

endmodule

// File: main_decoder.sv
`timescale 1ns/1ns

module main_decoder (
    input  riscv_pkg::opcode_t op,
    input  logic               zero,
    output riscv_pkg::ctrl_t   ctrl,
    output logic               pc_src
);
    import riscv_pkg::*;

    always_comb begin
        // inactive controls, also used for unknown opcodes
        ctrl.reg_write  = 1'b0;
        ctrl.imm_src    = imm_i;
        ctrl.alu_src    = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.result_src = res_alu;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.alu_op     = alu_op_add;

        case (op)
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;     // base + offset
                ctrl.result_src = res_mem;
            end
            op_store: begin
                ctrl.imm_src    = imm_s;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            op_rtype: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = alu_op_func;
            end
            op_itype: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = alu_op_func;
            end
            op_branch: begin
                ctrl.imm_src    = imm_b;
                ctrl.branch     = 1'b1;
                ctrl.alu_op     = alu_op_sub;  // zero flag means equal
            end
            op_lui: begin
                ctrl.reg_write  = 1'b1;
                ctrl.imm_src    = imm_u;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = alu_op_passb;
            end
            op_jal: begin
                ctrl.reg_write  = 1'b1;
                ctrl.imm_src    = imm_j;
                ctrl.result_src = res_pc4;     // link address into rd
                ctrl.jump       = 1'b1;
            end
            default: begin
                ctrl.reg_write  = 1'b0;
            end
        endcase
    end

    // taken beq or any jal
    assign pc_src = (ctrl.branch & zero) | ctrl.jump;

endmodule

// File: project.f
riscv_pkg.sv
alu.sv
reg_file.sv
imm_extend.sv
main_decoder.sv
alu_decoder.sv
datapath.sv
riscv_core.sv
tb_clock.sv
riscv_core_asserts.sv
tb_riscv_core.sv

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             we,
    input  logic [riscv_pkg::reg_addr_w-1:0] ra1,
    input  logic [riscv_pkg::reg_addr_w-1:0] ra2,
    input  logic [riscv_pkg::reg_addr_w-1:0] wa,
    input  logic [riscv_pkg::xlen-1:0]       wd,
    output logic [riscv_pkg::xlen-1:0]       rd1,
    output logic [riscv_pkg::xlen-1:0]       rd2
);
    import riscv_pkg::*;

    logic [xlen-1:0] regs [0:(1 << reg_addr_w)-1];

    // no write while in reset, x0 never written
    always_ff @(posedge clk) begin
        if (rst_n && we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];  // x0 reads as zero
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: riscv_core.sv
`timescale 1ns/1ns

module riscv_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  riscv_pkg::instr_t          instr,
    input  logic [riscv_pkg::xlen-1:0] read_data,
    output logic [riscv_pkg::xlen-1:0] pc,
    output logic [riscv_pkg::xlen-1:0] data_addr,
    output logic [riscv_pkg::xlen-1:0] write_data,
    output logic                       mem_write
);
    import riscv_pkg::*;

    ctrl_t     ctrl;
    alu_ctrl_t alu_ctrl;
    logic      pc_src;
    logic      zero;

    main_decoder u_main_decoder (
        .op     (instr.r_fmt.opcode),
        .zero   (zero),
        .ctrl   (ctrl),
        .pc_src (pc_src)
    );

    // op bit 5 separates r-type from i-type
    alu_decoder u_alu_decoder (
        .alu_op    (ctrl.alu_op),
        .funct3    (instr.r_fmt.funct3),
        .funct7_b5 (instr.r_fmt.funct7[5]),
        .op_b5     (instr.r_fmt.opcode[5]),
        .alu_ctrl  (alu_ctrl)
    );

    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .pc_src     (pc_src),
        .alu_ctrl   (alu_ctrl),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .zero       (zero),
        .mem_write  (mem_write)
    );

endmodule

// File: riscv_core_asserts.sv
`timescale 1ns/1ns

module riscv_core_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input riscv_pkg::instr_t          instr,
    input logic [riscv_pkg::xlen-1:0] pc,
    input logic                       mem_write
);
    import riscv_pkg::*;

    int fail_count = 0;

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc is not word aligned");
        end

    pc_after_reset: assert property (@(posedge clk) !rst_n |=> pc == '0)
        else begin
            fail_count++;
            $error("pc is not zero after a reset edge");
        end

    mem_write_known: assert property (@(posedge clk) disable iff (!rst_n)
                                      !$isunknown(mem_write))
        else begin
            fail_count++;
            $error("mem_write is unknown");
        end

    // stores are the only opcode that may write memory
    write_on_store: assert property (@(posedge clk) disable iff (!rst_n)
                                     mem_write == (instr.r_fmt.opcode == op_store))
        else begin
            fail_count++;
            $error("mem_write does not match the store opcode");
        end

endmodule

bind riscv_core riscv_core_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr     (instr),
    .pc        (pc),
    .mem_write (mem_write)
);

// File: riscv_pkg.sv
package riscv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111
    } opcode_t;

    // class handed from the main decoder to the alu decoder
    typedef enum logic [1:0] {
        alu_op_add   = 2'b00,  // address calc for lw/sw
        alu_op_sub   = 2'b01,  // beq compare
        alu_op_func  = 2'b10,  // look at funct3/funct7
        alu_op_passb = 2'b11   // lui
    } alu_op_t;

    typedef enum logic [2:0] {
        alu_add   = 3'b000,
        alu_sub   = 3'b001,
        alu_and   = 3'b010,
        alu_or    = 3'b011,
        alu_slt   = 3'b101,
        alu_passb = 3'b110
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        imm_i = 3'b000,
        imm_s = 3'b001,
        imm_b = 3'b010,
        imm_j = 3'b011,
        imm_u = 3'b100
    } imm_src_t;

    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01,
        res_pc4 = 2'b10
    } result_src_t;

    typedef struct packed {
        logic        reg_write;
        imm_src_t    imm_src;
        logic        alu_src;     // 1 selects the immediate as alu b
        logic        mem_write;
        result_src_t result_src;
        logic        branch;
        logic        jump;
        alu_op_t     alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm4_0;
        opcode_t               opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        opcode_t               opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm31_12;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [reg_addr_w-1:0] rd;
        opcode_t               opcode;
    } j_fmt_t;

    // one fetched word, seen through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage

// File: tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #10 clk = ~clk;  // 20 ns period

endmodule

// File: tb_riscv_core.sv
`timescale 1ns/1ns

module tb_riscv_core;
    import riscv_pkg::*;

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] pc;        // expected pc at fetch
        logic        mem_write;
        logic [31:0] addr;      // checked on stores only
        logic [31:0] wdata;
    } row_t;

    logic        clk;
    logic        rst_n;
    instr_t      instr;
    logic [31:0] read_data;
    logic [31:0] pc;
    logic [31:0] data_addr;
    logic [31:0] write_data;
    logic        mem_write;
    logic [31:0] dmem [0:63];
    logic [31:0] shadow [0:63];   // untouched copy of the preload
    row_t        prog [$];
    int          errors = 0;
    int          seed;

    tb_clock u_clock (.clk(clk));

    riscv_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_write  (mem_write)
    );

    assign read_data = dmem[data_addr[7:2]];  // combinational load

    always @(posedge clk) begin
        if (mem_write === 1'b1) begin
            dmem[data_addr[7:2]] <= write_data;
        end
    end

    function automatic logic [31:0] alu_reg(input logic [2:0] f3, input logic sub_bit,
                                            input logic [4:0] rd, rs1, rs2);
        return {1'b0, sub_bit, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] alu_imm(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_eq(input logic [4:0] rs1, rs2,
                                              input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic plain_row(input logic [31:0] word, input logic [31:0] row_pc);
        prog.push_back({word, row_pc, 1'b0, 32'h0, 32'h0});
    endtask

    task automatic store_row(input logic [31:0] word, row_pc, addr, wdata);
        prog.push_back({word, row_pc, 1'b1, addr, wdata});
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected, actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    initial begin : reset_seq
        rst_n = 1'b0;
        repeat (3) begin
            @(negedge clk);
            compare_value("mem_write", 32'h0, {31'b0, mem_write});  // sw held on instr
        end
        rst_n = 1'b1;
    end

    initial begin : main_seq
        int i;
        int waited;
        int steps;
        int step_limit;
        seed = 32'ha77;
        step_limit = 64;
        instr = store_word(5'd1, 5'd0, 12'd0);
        for (i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
            shadow[i] = dmem[i];
        end
        plain_row(alu_imm(3'b000, 1, 0, 5), 0);            // x1 = 5
        plain_row(alu_imm(3'b000, 2, 0, 12'hffd), 4);      // x2 = -3
        plain_row(alu_imm(3'b111, 3, 1, 6), 8);            // x3 = 4
        plain_row(alu_imm(3'b110, 4, 1, 12'h010), 12);     // x4 = 0x15
        plain_row(alu_imm(3'b010, 5, 2, 1), 16);           // signed, x5 = 1
        store_row(store_word(3, 0, 0), 20, 0, 32'h4);
        store_row(store_word(4, 0, 4), 24, 4, 32'h15);
        store_row(store_word(5, 0, 8), 28, 8, 32'h1);
        plain_row(alu_reg(3'b000, 0, 6, 1, 2), 32);        // x6 = 2
        plain_row(alu_reg(3'b000, 1, 7, 1, 2), 36);        // x7 = 8
        plain_row(alu_reg(3'b111, 0, 8, 1, 2), 40);        // x8 = 5
        plain_row(alu_reg(3'b110, 0, 9, 1, 2), 44);        // x9 = -3
        plain_row(alu_reg(3'b010, 0, 10, 2, 1), 48);       // -3 < 5
        plain_row(alu_reg(3'b010, 0, 11, 1, 2), 52);
        store_row(store_word(6, 1, 11), 56, 16, 32'h2);    // base x1 = 5
        store_row(store_word(7, 1, 15), 60, 20, 32'h8);
        store_row(store_word(8, 0, 24), 64, 24, 32'h5);
        store_row(store_word(9, 0, 28), 68, 28, 32'hffff_fffd);
        store_row(store_word(10, 0, 32), 72, 32, 32'h1);
        store_row(store_word(11, 0, 36), 76, 36, 32'h0);
        plain_row(load_word(12, 0, 160), 80);              // word 40
        plain_row(load_word(13, 1, 175), 84);              // word 45
        store_row(store_word(12, 0, 40), 88, 40, shadow[40]);
        store_row(store_word(13, 0, 44), 92, 44, shadow[45]);
        plain_row(branch_eq(1, 2, 16), 96);                // not taken
        plain_row(branch_eq(3, 3, 12), 100);               // taken to 112
        plain_row(upper_imm(14, 20'h12345), 112);
        plain_row(upper_imm(15, 20'hfffff), 116);
        store_row(store_word(14, 0, 48), 120, 48, 32'h1234_5000);
        store_row(store_word(15, 0, 52), 124, 52, 32'hffff_f000);
        plain_row(jump_link(16, 12), 128);                 // to 140, link 132
        store_row(store_word(16, 0, 56), 140, 56, 32'd132);
        plain_row(alu_imm(3'b000, 0, 1, 7), 144);          // x0 stays zero
        store_row(store_word(0, 0, 60), 148, 60, 32'h0);
        plain_row(jump_link(17, -20), 152);                // back to 132
        store_row(store_word(17, 0, 64), 132, 64, 32'd156);

        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(posedge clk or posedge rst_n);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within 20 cycles");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            steps = 0;
            for (i = 0; i < prog.size() && steps < step_limit; i++) begin
                compare_value("pc", prog[i].pc, pc);
                instr = prog[i].word;
                #2;
                compare_value("mem_write", {31'b0, prog[i].mem_write}, {31'b0, mem_write});
                if (prog[i].mem_write) begin
                    compare_value("data_addr", prog[i].addr, data_addr);
                    compare_value("write_data", prog[i].wdata, write_data);
                end
                steps++;
                @(negedge clk);
            end
            if (i < prog.size()) begin
                errors++;
                $display("program stopped at the step limit before its last row");
            end
            $display("check errors: %0d, assertion failures: %0d", errors,
                     DUT.u_asserts.fail_count);
            if (errors == 0 && DUT.u_asserts.fail_count == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule
